// ==== source/modem_params.svh ====
`ifndef MODEM_PARAMS_SVH
`define MODEM_PARAMS_SVH

// unsigned received and reference samples
`define MODEM_DATA_WIDTH 8

// preamble shape, sent msb first
`define MODEM_WAVELENGTH 4
`define MODEM_PREAMBLE_LENGTH 8
`define MODEM_PREAMBLE 8'b10110010

// two-level waveform around the mid level
`define MODEM_AMPLITUDE 64
`define MODEM_SWING 48

// correlation sizes
`define MODEM_SUM_COUNT 4
`define MODEM_SAMPLE_COUNT (`MODEM_WAVELENGTH * `MODEM_PREAMBLE_LENGTH)
`define MODEM_SUM_TIME (`MODEM_SAMPLE_COUNT / `MODEM_SUM_COUNT)

// worst case sum is SAMPLE_COUNT * 255, fits in 14 bits
`define MODEM_SAD_WIDTH 14

`endif

// ==== source/modem_pkg.sv ====
`include "modem_params.svh"

package modem_pkg;

    typedef struct packed {
        logic [4:0]  paddr;
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [4:0] {
        REG_CTRL       = 5'h00,
        REG_THRESHOLD  = 5'h04,
        REG_STATUS     = 5'h08,
        REG_MIN_SAD    = 5'h0C,
        REG_LOCK_INDEX = 5'h10
    } reg_addr_e;

    // clear is an action bit and reads back as zero
    typedef struct packed {
        logic [29:0] reserved;
        logic        clear;
        logic        enable;
    } ctrl_word_t;

    // the write word means a control word or a threshold, by address
    typedef union packed {
        ctrl_word_t  ctrl;
        logic [31:0] threshold;
    } apb_wdata_u;

    typedef struct packed {
        logic [`MODEM_SAD_WIDTH-1:0] sum;
        logic                        valid;
    } sad_result_t;

endpackage

// ==== source/preamble_modulator.sv ====
`include "modem_params.svh"

module preamble_modulator (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         ref_start,
    output logic [`MODEM_DATA_WIDTH-1:0] ref_sample,
    output logic                         ref_valid,
    output logic                         ref_done
);

    localparam int DATA_WIDTH = `MODEM_DATA_WIDTH;
    localparam int WAVELENGTH = `MODEM_WAVELENGTH;
    localparam int PREAMBLE_LENGTH = `MODEM_PREAMBLE_LENGTH;
    localparam logic [PREAMBLE_LENGTH-1:0] PREAMBLE = `MODEM_PREAMBLE;
    localparam logic [DATA_WIDTH-1:0] LEVEL_HIGH = DATA_WIDTH'(`MODEM_AMPLITUDE + `MODEM_SWING);
    localparam logic [DATA_WIDTH-1:0] LEVEL_LOW = DATA_WIDTH'(`MODEM_AMPLITUDE - `MODEM_SWING);

    logic                               active;
    logic [$clog2(PREAMBLE_LENGTH)-1:0] bit_cnt;
    logic [$clog2(WAVELENGTH)-1:0]      phase_cnt;
    logic                               last_phase;
    logic                               cur_bit;
    logic                               second_half;

    assign last_phase = (phase_cnt == WAVELENGTH - 1);
    assign cur_bit = PREAMBLE[PREAMBLE_LENGTH - 1 - bit_cnt];
    assign second_half = (phase_cnt >= WAVELENGTH / 2);

    // a 1 bit starts high and ends low, a 0 bit the other way round
    assign ref_sample = (cur_bit ^ second_half) ? LEVEL_HIGH : LEVEL_LOW;
    assign ref_valid = active;
    assign ref_done = active && last_phase && (bit_cnt == PREAMBLE_LENGTH - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            bit_cnt <= '0;
            phase_cnt <= '0;
        end else if (ref_start) begin
            active <= 1'b1;
            bit_cnt <= '0;
            phase_cnt <= '0;
        end else if (active) begin
            if (last_phase) begin
                phase_cnt <= '0;
                bit_cnt <= bit_cnt + 1'b1;
            end else begin
                phase_cnt <= phase_cnt + 1'b1;
            end
            if (ref_done) begin
                active <= 1'b0;
                bit_cnt <= '0;
            end
        end
    end

endmodule

// ==== source/sample_window.sv ====
`include "modem_params.svh"

module sample_window (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic [`MODEM_DATA_WIDTH-1:0]                           sample,
    input  logic                                                   shift,
    input  logic [`MODEM_DATA_WIDTH-1:0]                           ref_sample,
    input  logic                                                   ref_valid,
    input  logic [$clog2(`MODEM_SUM_TIME)-1:0]                     slice_index,
    output logic signed [`MODEM_SUM_COUNT-1:0][`MODEM_DATA_WIDTH:0] rx_slice,
    output logic signed [`MODEM_SUM_COUNT-1:0][`MODEM_DATA_WIDTH:0] ref_slice
);

    localparam int DATA_WIDTH = `MODEM_DATA_WIDTH;
    localparam int CENTER_WIDTH = DATA_WIDTH + 1;
    localparam int SUM_COUNT = `MODEM_SUM_COUNT;
    localparam int SAMPLE_COUNT = `MODEM_SAMPLE_COUNT;
    localparam logic [CENTER_WIDTH-1:0] OFFSET = CENTER_WIDTH'(`MODEM_AMPLITUDE);

    // position 0 holds the newest sample
    logic [SAMPLE_COUNT-1:0][CENTER_WIDTH-1:0] rx_window;
    logic [SAMPLE_COUNT-1:0][CENTER_WIDTH-1:0] ref_window;
    logic [CENTER_WIDTH-1:0]                   rx_centered;
    logic [CENTER_WIDTH-1:0]                   ref_centered;

    // remove the mid level, result is signed
    assign rx_centered = {1'b0, sample} - OFFSET;
    assign ref_centered = {1'b0, ref_sample} - OFFSET;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_window <= '0;
        end else if (shift) begin
            rx_window <= {rx_window[SAMPLE_COUNT-2:0], rx_centered};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ref_window <= '0;
        end else if (ref_valid) begin
            ref_window <= {ref_window[SAMPLE_COUNT-2:0], ref_centered};
        end
    end

    // slice n covers positions n*SUM_COUNT up to n*SUM_COUNT+SUM_COUNT-1
    assign rx_slice = rx_window[slice_index * SUM_COUNT +: SUM_COUNT];
    assign ref_slice = ref_window[slice_index * SUM_COUNT +: SUM_COUNT];

endmodule

// ==== source/sad_accumulator.sv ====
`include "modem_params.svh"

module sad_accumulator (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    input  logic                                                   sad_start,
    input  logic signed [`MODEM_SUM_COUNT-1:0][`MODEM_DATA_WIDTH:0] rx_slice,
    input  logic signed [`MODEM_SUM_COUNT-1:0][`MODEM_DATA_WIDTH:0] ref_slice,
    output logic [$clog2(`MODEM_SUM_TIME)-1:0]                     slice_index,
    output logic                                                   busy,
    output modem_pkg::sad_result_t                                 result
);

    localparam int CENTER_WIDTH = `MODEM_DATA_WIDTH + 1;
    localparam int SUM_COUNT = `MODEM_SUM_COUNT;
    localparam int SUM_TIME = `MODEM_SUM_TIME;
    localparam int SAD_WIDTH = `MODEM_SAD_WIDTH;
    localparam int INDEX_WIDTH = $clog2(SUM_TIME);

    logic signed [CENTER_WIDTH:0] diff [SUM_COUNT];
    logic [CENTER_WIDTH-1:0]      abs_diff [SUM_COUNT];
    logic [SAD_WIDTH-1:0]         slice_sum;
    logic [SAD_WIDTH-1:0]         acc;
    logic [SAD_WIDTH-1:0]         result_sum;
    logic                         result_valid;
    logic                         last_slice;

    for (genvar j = 0; j < SUM_COUNT; j++) begin : g_diff
        assign diff[j] = $signed(rx_slice[j]) - $signed(ref_slice[j]);
        assign abs_diff[j] = diff[j][CENTER_WIDTH] ? CENTER_WIDTH'(-diff[j])
                                                   : CENTER_WIDTH'(diff[j]);
    end

    always_comb begin
        slice_sum = '0;
        for (int j = 0; j < SUM_COUNT; j++) begin
            slice_sum = slice_sum + SAD_WIDTH'(abs_diff[j]);
        end
    end

    assign last_slice = (slice_index == INDEX_WIDTH'(SUM_TIME - 1));

    // slice 0 is already presented while idle, so it is summed in the start cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            slice_index <= '0;
            result_valid <= 1'b0;
        end else begin
            result_valid <= 1'b0;
            if (sad_start) begin
                busy <= 1'b1;
                slice_index <= INDEX_WIDTH'(1);
            end else if (busy) begin
                if (last_slice) begin
                    busy <= 1'b0;
                    slice_index <= '0;
                    result_valid <= 1'b1;
                end else begin
                    slice_index <= slice_index + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sad_start) begin
            acc <= slice_sum;
        end else if (busy) begin
            acc <= acc + slice_sum;
            if (last_slice) begin
                result_sum <= acc + slice_sum;
            end
        end
    end

    assign result = '{sum: result_sum, valid: result_valid};

endmodule

// ==== source/sync_control.sv ====
`include "modem_params.svh"

module sync_control (
    input  logic                   clk,
    input  logic                   rst_n,
    input  modem_pkg::apb_req_t    apb_req,
    output modem_pkg::apb_rsp_t    apb_rsp,
    input  logic                   sample_valid,
    input  logic                   ref_done,
    input  logic                   busy,
    input  modem_pkg::sad_result_t result,
    output logic                   ref_start,
    output logic                   shift,
    output logic                   sad_start,
    output logic                   lock
);

    import modem_pkg::*;

    localparam int SAD_WIDTH = `MODEM_SAD_WIDTH;
    localparam int SAMPLE_COUNT = `MODEM_SAMPLE_COUNT;
    localparam int COUNT_WIDTH = 16;
    localparam logic [31:0] THRESHOLD_RESET = 32'h200;

    apb_wdata_u             wdata;
    logic                   access;
    logic                   write_ctrl;
    logic                   write_threshold;
    logic                   addr_ok;
    logic                   clear_evt;
    logic                   enable;
    logic                   enable_d;
    logic                   ref_ready;
    logic                   overrun;
    logic [31:0]            threshold;
    logic [SAD_WIDTH-1:0]   min_sad;
    logic [COUNT_WIDTH-1:0] sample_cnt;
    logic [COUNT_WIDTH-1:0] lock_index;
    logic                   corr_active;
    logic                   lock_hit;
    logic                   window_full;

    assign wdata = apb_req.pwdata;
    assign access = apb_req.psel && apb_req.penable;
    assign write_ctrl = access && apb_req.pwrite && (apb_req.paddr == REG_CTRL);
    assign write_threshold = access && apb_req.pwrite && (apb_req.paddr == REG_THRESHOLD);

    // clear bit or dropped enable restarts the search
    assign clear_evt = write_ctrl && (wdata.ctrl.clear || !wdata.ctrl.enable);

    assign ref_start = enable && !enable_d;
    assign corr_active = busy || sad_start;
    assign lock_hit = result.valid && (32'(result.sum) < threshold);
    // the sample being accepted now completes the window
    assign window_full = (sample_cnt >= COUNT_WIDTH'(SAMPLE_COUNT - 1));
    assign shift = sample_valid && ref_ready && !lock && !lock_hit && !corr_active;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enable <= 1'b0;
            enable_d <= 1'b0;
            ref_ready <= 1'b0;
            threshold <= THRESHOLD_RESET;
        end else begin
            enable_d <= enable;
            if (write_ctrl) begin
                enable <= wdata.ctrl.enable;
            end
            if (write_threshold) begin
                threshold <= wdata.threshold;
            end
            if (write_ctrl && !wdata.ctrl.enable) begin
                ref_ready <= 1'b0;
            end else if (ref_done && enable) begin
                ref_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sad_start <= 1'b0;
            sample_cnt <= '0;
            lock <= 1'b0;
            lock_index <= '0;
            overrun <= 1'b0;
            min_sad <= '1;
        end else begin
            sad_start <= shift && window_full && !clear_evt;
            if (clear_evt) begin
                sample_cnt <= '0;
                lock <= 1'b0;
                overrun <= 1'b0;
                min_sad <= '1;
            end else begin
                // count saturates instead of wrapping
                if (shift && (sample_cnt != '1)) begin
                    sample_cnt <= sample_cnt + 1'b1;
                end
                if (sample_valid && ref_ready && !lock && corr_active) begin
                    overrun <= 1'b1;
                end
                if (result.valid && (result.sum < min_sad)) begin
                    min_sad <= result.sum;
                end
                if (lock_hit) begin
                    lock <= 1'b1;
                    lock_index <= sample_cnt;
                end
            end
        end
    end

    // read mux, no wait states
    always_comb begin
        apb_rsp.prdata = '0;
        apb_rsp.pready = 1'b1;
        addr_ok = 1'b1;
        case (apb_req.paddr)
            REG_CTRL:       apb_rsp.prdata = ctrl_word_t'{reserved: '0, clear: 1'b0, enable: enable};
            REG_THRESHOLD:  apb_rsp.prdata = threshold;
            REG_STATUS:     apb_rsp.prdata = {28'b0, corr_active, overrun, lock, ref_ready};
            REG_MIN_SAD:    apb_rsp.prdata = 32'(min_sad);
            REG_LOCK_INDEX: apb_rsp.prdata = 32'(lock_index);
            default:        addr_ok = 1'b0;
        endcase
        apb_rsp.pslverr = access && !addr_ok;
    end

endmodule

// ==== source/preamble_sync.sv ====
`include "modem_params.svh"

module preamble_sync (
    input  logic                         clk,
    input  logic                         rst_n,
    input  modem_pkg::apb_req_t          apb_req,
    output modem_pkg::apb_rsp_t          apb_rsp,
    input  logic [`MODEM_DATA_WIDTH-1:0] sample,
    input  logic                         sample_valid,
    output logic                         lock
);

    import modem_pkg::*;

    localparam int DATA_WIDTH = `MODEM_DATA_WIDTH;
    localparam int SUM_COUNT = `MODEM_SUM_COUNT;
    localparam int INDEX_WIDTH = $clog2(`MODEM_SUM_TIME);

    logic                                 ref_start;
    logic                                 ref_valid;
    logic                                 ref_done;
    logic [DATA_WIDTH-1:0]                ref_sample;
    logic                                 shift;
    logic                                 sad_start;
    logic                                 busy;
    logic [INDEX_WIDTH-1:0]               slice_index;
    logic [SUM_COUNT-1:0][DATA_WIDTH:0]   rx_slice;
    logic [SUM_COUNT-1:0][DATA_WIDTH:0]   ref_slice;
    sad_result_t                          result;

    sync_control u_sync_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .sample_valid (sample_valid),
        .ref_done     (ref_done),
        .busy         (busy),
        .result       (result),
        .ref_start    (ref_start),
        .shift        (shift),
        .sad_start    (sad_start),
        .lock         (lock)
    );

    preamble_modulator u_preamble_modulator (
        .clk        (clk),
        .rst_n      (rst_n),
        .ref_start  (ref_start),
        .ref_sample (ref_sample),
        .ref_valid  (ref_valid),
        .ref_done   (ref_done)
    );

    sample_window u_sample_window (
        .clk         (clk),
        .rst_n       (rst_n),
        .sample      (sample),
        .shift       (shift),
        .ref_sample  (ref_sample),
        .ref_valid   (ref_valid),
        .slice_index (slice_index),
        .rx_slice    (rx_slice),
        .ref_slice   (ref_slice)
    );

    sad_accumulator u_sad_accumulator (
        .clk         (clk),
        .rst_n       (rst_n),
        .sad_start   (sad_start),
        .rx_slice    (rx_slice),
        .ref_slice   (ref_slice),
        .slice_index (slice_index),
        .busy        (busy),
        .result      (result)
    );

endmodule

// ==== sim/preamble_sync_props.sv ====
`include "modem_params.svh"

module preamble_sync_props (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   sad_start,
    input modem_pkg::sad_result_t result,
    input logic                   lock,
    input modem_pkg::apb_rsp_t    apb_rsp,
    input logic                   shift,
    input logic [31:0]            threshold
);

    localparam int SUM_TIME = `MODEM_SUM_TIME;

    int fail_count = 0;

    // serial sum takes one cycle per slice
    a_result_timing: assert property (@(posedge clk) disable iff (!rst_n)
        sad_start |-> ##SUM_TIME result.valid)
        else begin
            fail_count++;
            $error("result.valid did not come SUM_TIME cycles after sad_start");
        end

    // lock only follows a result below the threshold
    a_lock_cause: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(lock) |-> $past(result.valid && (32'(result.sum) < threshold)))
        else begin
            fail_count++;
            $error("lock rose without a valid result below the threshold");
        end

    a_pready_high: assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp.pready)
        else begin
            fail_count++;
            $error("pready went low");
        end

    // the window holds still for the whole serial sum
    a_no_shift_busy: assert property (@(posedge clk) disable iff (!rst_n)
        sad_start |-> !shift [*SUM_TIME])
        else begin
            fail_count++;
            $error("window shifted during a correlation");
        end

    a_lock_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !lock)
        else begin
            fail_count++;
            $error("lock was high when reset was released");
        end

endmodule

bind preamble_sync preamble_sync_props u_preamble_sync_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .sad_start (sad_start),
    .result    (result),
    .lock      (lock),
    .apb_rsp   (apb_rsp),
    .shift     (shift),
    .threshold (u_sync_control.threshold)
);

// ==== sim/preamble_sync_tb.sv ====
`include "modem_params.svh"

module preamble_sync_tb;

    import modem_pkg::*;

    localparam int DATA_WIDTH = `MODEM_DATA_WIDTH;
    localparam int WAVELENGTH = `MODEM_WAVELENGTH;
    localparam int PREAMBLE_LENGTH = `MODEM_PREAMBLE_LENGTH;
    localparam logic [PREAMBLE_LENGTH-1:0] PREAMBLE = `MODEM_PREAMBLE;
    localparam int AMPLITUDE = `MODEM_AMPLITUDE;
    localparam int SWING = `MODEM_SWING;
    localparam int SAMPLE_COUNT = `MODEM_SAMPLE_COUNT;
    localparam int SUM_TIME = `MODEM_SUM_TIME;
    localparam int SAD_ALL_ONES = (1 << `MODEM_SAD_WIDTH) - 1;
    localparam int APB_TIMEOUT = 16;
    localparam int FILL_TIMEOUT = 64;

    logic                  clk;
    logic                  rst_n;
    apb_req_t              apb_req;
    apb_rsp_t              apb_rsp;
    logic [DATA_WIDTH-1:0] sample;
    logic                  sample_valid;
    logic                  lock;

    // reference model, window position 0 is the newest sample
    int window_m [SAMPLE_COUNT];
    int count_m;
    int min_m;
    int threshold_m;
    int lock_index_m;
    bit lock_m;
    bit ready_m;
    int errors;
    int timeouts;

    preamble_sync u_preamble_sync (
        .clk          (clk),
        .rst_n        (rst_n),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .sample       (sample),
        .sample_valid (sample_valid),
        .lock         (lock)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic end_run();
        int assert_fails;
        assert_fails = u_preamble_sync.u_preamble_sync_props.fail_count;
        $display("value errors: %0d, assertion failures: %0d, timeouts: %0d",
                 errors, assert_fails, timeouts);
        if (errors == 0 && assert_fails == 0 && timeouts == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic abort_on_timeout(input string what);
        timeouts++;
        $display("timeout: no response while waiting for %s", what);
        end_run();
    endtask

    task automatic check_equal(input string what, input int got, input int expected);
        assert (got == expected) else begin
            errors++;
            $display("** Error at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, what, got, expected);
        end
    endtask

    task automatic apb_transfer(input logic [4:0] addr, input logic write,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic slverr);
        int wait_cycles;
        apb_req.paddr = addr;
        apb_req.pwrite = write;
        apb_req.pwdata = wdata;
        apb_req.psel = 1'b1;
        apb_req.penable = 1'b0;
        @(posedge clk);
        #2 apb_req.penable = 1'b1;
        wait_cycles = 0;
        // response is sampled mid-cycle where the read mux has settled
        @(negedge clk);
        while (!apb_rsp.pready) begin
            wait_cycles++;
            if (wait_cycles > APB_TIMEOUT) begin
                abort_on_timeout("pready");
            end
            @(negedge clk);
        end
        rdata = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        @(posedge clk);
        #2 apb_req.psel = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        slverr;
        apb_transfer(addr, 1'b1, wdata, rdata, slverr);
        check_equal("pslverr on write", slverr, 0);
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] rdata,
                            output logic slverr);
        apb_transfer(addr, 1'b0, 32'h0, rdata, slverr);
    endtask

    // a 1 bit is high then low over its wavelength, a 0 bit low then high
    function automatic int ref_level(input int pos);
        logic bit_value;
        logic first_half;
        bit_value = PREAMBLE[PREAMBLE_LENGTH - 1 - pos / WAVELENGTH];
        first_half = (pos % WAVELENGTH) < WAVELENGTH / 2;
        if (bit_value == first_half) begin
            return AMPLITUDE + SWING;
        end
        return AMPLITUDE - SWING;
    endfunction

    function automatic int window_sad();
        int sum;
        int diff;
        sum = 0;
        for (int k = 0; k < SAMPLE_COUNT; k++) begin
            diff = window_m[k] - ref_level(SAMPLE_COUNT - 1 - k);
            sum += (diff < 0) ? -diff : diff;
        end
        return sum;
    endfunction

    function automatic void model_accept(input int value);
        int sad;
        if (!ready_m || lock_m) begin
            return;
        end
        for (int k = SAMPLE_COUNT - 1; k > 0; k--) begin
            window_m[k] = window_m[k - 1];
        end
        window_m[0] = value;
        count_m++;
        if (count_m >= SAMPLE_COUNT) begin
            sad = window_sad();
            if (sad < min_m) begin
                min_m = sad;
            end
            if (sad < threshold_m) begin
                lock_m = 1'b1;
                lock_index_m = count_m;
            end
        end
    endfunction

    function automatic void model_clear();
        count_m = 0;
        lock_m = 1'b0;
        min_m = SAD_ALL_ONES;
    endfunction

    // one strobe, then idle until a lock from this sample would be visible
    task automatic send_sample(input int value);
        sample = DATA_WIDTH'(value);
        sample_valid = 1'b1;
        @(posedge clk);
        #2 sample_valid = 1'b0;
        model_accept(value);
        repeat (SUM_TIME + 1) @(posedge clk);
        #2;
        check_equal("lock", lock, lock_m);
    endtask

    // second strobe lands while the first one is being correlated
    task automatic send_overrun_pair(input int first, input int second);
        sample = DATA_WIDTH'(first);
        sample_valid = 1'b1;
        @(posedge clk);
        #2 sample = DATA_WIDTH'(second);
        @(posedge clk);
        #2 sample_valid = 1'b0;
        model_accept(first);
        repeat (SUM_TIME) @(posedge clk);
        #2;
        check_equal("lock", lock, lock_m);
    endtask

    task automatic send_filler(input int count);
        repeat (count) send_sample($urandom_range(255, 0));
    endtask

    task automatic send_preamble();
        for (int i = 0; i < SAMPLE_COUNT; i++) begin
            send_sample(ref_level(i));
        end
    endtask

    task automatic set_threshold(input int value);
        apb_write(REG_THRESHOLD, value);
        threshold_m = value;
    endtask

    task automatic wait_ref_ready();
        logic [31:0] status;
        logic        slverr;
        int          polls;
        polls = 0;
        apb_read(REG_STATUS, status, slverr);
        while (!status[0]) begin
            polls++;
            if (polls > FILL_TIMEOUT) begin
                abort_on_timeout("ref_ready");
            end
            apb_read(REG_STATUS, status, slverr);
        end
    endtask

    task automatic check_register(input logic [4:0] addr, input string what,
                                  input int expected);
        logic [31:0] rdata;
        logic        slverr;
        apb_read(addr, rdata, slverr);
        check_equal(what, rdata, expected);
        check_equal({"pslverr on ", what}, slverr, 0);
    endtask

    initial begin
        logic [31:0] rdata;
        logic        slverr;
        errors = 0;
        timeouts = 0;
        void'($urandom(32'hc92365b0));
        rst_n = 1'b0;
        apb_req = '0;
        sample = '0;
        sample_valid = 1'b0;
        for (int k = 0; k < SAMPLE_COUNT; k++) begin
            window_m[k] = AMPLITUDE;
        end
        model_clear();
        threshold_m = 32'h200;
        lock_index_m = 0;
        ready_m = 1'b0;
        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;
        @(posedge clk);
        #2;

        // register access and decode error
        check_register(REG_THRESHOLD, "THRESHOLD after reset", 32'h200);
        check_register(REG_MIN_SAD, "MIN_SAD after reset", SAD_ALL_ONES);
        set_threshold(32'h155);
        check_register(REG_THRESHOLD, "THRESHOLD readback", threshold_m);
        apb_read(5'h14, rdata, slverr);
        check_equal("pslverr at 0x14", slverr, 1);
        check_equal("read data at 0x14", rdata, 0);

        // reference fill after enable
        apb_write(REG_CTRL, ctrl_word_t'{reserved: '0, clear: 1'b0, enable: 1'b1});
        wait_ref_ready();
        ready_m = 1'b1;

        // random samples with a low threshold
        set_threshold(32'h20);
        send_filler(40);
        check_equal("lock on random samples", lock, 0);
        check_register(REG_MIN_SAD, "MIN_SAD over random samples", min_m);

        // back to back strobes drop the second one
        send_overrun_pair($urandom_range(255, 0), $urandom_range(255, 0));
        apb_read(REG_STATUS, rdata, slverr);
        check_equal("STATUS overrun", rdata[2], 1);

        // preamble after filler
        send_filler(5);
        send_preamble();
        check_equal("lock on preamble", lock, 1);
        check_register(REG_LOCK_INDEX, "LOCK_INDEX", lock_index_m);
        check_register(REG_MIN_SAD, "MIN_SAD after lock", min_m);

        // clear and lock a second time
        apb_write(REG_CTRL, ctrl_word_t'{reserved: '0, clear: 1'b1, enable: 1'b1});
        model_clear();
        apb_read(REG_STATUS, rdata, slverr);
        check_equal("STATUS lock after clear", rdata[1], 0);
        check_equal("STATUS overrun after clear", rdata[2], 0);
        check_equal("lock after clear", lock, 0);
        send_filler(6);
        send_preamble();
        check_equal("lock on second preamble", lock, 1);
        check_register(REG_LOCK_INDEX, "LOCK_INDEX after clear", lock_index_m);

        end_run();
    end

endmodule

// ==== preamble_sync.f ====
+incdir+source
source/modem_pkg.sv
source/preamble_modulator.sv
source/sample_window.sv
source/sad_accumulator.sv
source/sync_control.sv
source/preamble_sync.sv
sim/preamble_sync_props.sv
sim/preamble_sync_tb.sv
